// ==== include/uart_consts.svh ====
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// clock cycles per serial bit
`define UART_BIT_CYCLES 8

// idle cycles on tx between the high and the low command frame
`define UART_GAP_CYCLES 4

// cycles to wait for the start bit of a read reply
`define UART_REPLY_TIMEOUT 200

`endif

// ==== logic/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

  // host command, bit 15 is the write flag
  typedef struct packed {
    logic       write;
    logic [6:0] addr;
    logic [7:0] data;
  } uart_cmd_t;

  // one received frame with its line checks
  typedef struct packed {
    logic [7:0] data;
    logic       parity_err;
    logic       stop_err;
  } uart_rx_frame_t;

  // result of a read command
  typedef struct packed {
    logic [7:0] data;
    logic       err;  // parity, stop or timeout
  } uart_read_t;

endpackage

`default_nettype wire

// ==== logic/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_consts.svh"

module uart_tx #(
  parameter int BIT_CYCLES = `UART_BIT_CYCLES
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_start,
  input  logic [7:0] tx_byte,
  output logic       tx,
  output logic       tx_busy
);

  localparam int CNT_W = $clog2(BIT_CYCLES + 1);

  logic [CNT_W-1:0] baud_cnt;
  logic [3:0]       bit_idx;   // 0 start, 1..8 data, 9 parity, 10 stop
  logic [9:0]       shift_q;   // bits still to go after the start bit
  logic             bit_end;

  assign bit_end = (baud_cnt == CNT_W'(BIT_CYCLES - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx       <= 1'b1;
      tx_busy  <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end
    else if (!tx_busy)
    begin
      if (tx_start)
      begin
        tx       <= 1'b0;  // start bit
        tx_busy  <= 1'b1;
        baud_cnt <= '0;
        bit_idx  <= '0;
      end
    end
    else if (bit_end)
    begin
      baud_cnt <= '0;
      if (bit_idx == 4'd10)
      begin
        // stop bit done, line stays high
        tx      <= 1'b1;
        tx_busy <= 1'b0;
      end
      else
      begin
        bit_idx <= bit_idx + 4'd1;
        tx      <= shift_q[0];
      end
    end
    else
    begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  // stop, odd parity, data lsb first
  always_ff @(posedge clk)
  begin
    if (!tx_busy && tx_start)
    begin
      shift_q <= {1'b1, ~^tx_byte, tx_byte};
    end
    else if (tx_busy && bit_end)
    begin
      shift_q <= {1'b1, shift_q[9:1]};
    end
  end

endmodule

`default_nettype wire

// ==== logic/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_consts.svh"

module uart_rx #(
  parameter int BIT_CYCLES = `UART_BIT_CYCLES
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     rx,
  output uart_pkg::uart_rx_frame_t rx_frame,
  output logic                     rx_vld,
  output logic                     rx_active
);

  import uart_pkg::*;

  localparam int CNT_W     = $clog2(BIT_CYCLES + 1);
  // preload so the first tick lands half a bit after the start edge
  localparam int HALF_LOAD = BIT_CYCLES - BIT_CYCLES / 2;

  logic             rx_s1;
  logic             rx_s2;
  logic             rx_d;
  logic             active;
  logic [CNT_W-1:0] baud_cnt;
  logic [3:0]       bit_idx;
  logic [7:0]       data_sh;
  logic             par_err_q;
  logic             start_edge;
  logic             tick;
  uart_rx_frame_t   frame_d;

  assign start_edge = rx_d & ~rx_s2;
  assign tick       = active && (baud_cnt == CNT_W'(BIT_CYCLES - 1));
  assign rx_active  = active;
  assign frame_d    = '{data: data_sh, parity_err: par_err_q, stop_err: ~rx_s2};

  // two-flop synchronizer plus one stage for the edge detect, idle high
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_s1 <= 1'b1;
      rx_s2 <= 1'b1;
      rx_d  <= 1'b1;
    end
    else
    begin
      rx_s1 <= rx;
      rx_s2 <= rx_s1;
      rx_d  <= rx_s2;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      active   <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
      rx_vld   <= 1'b0;
    end
    else
    begin
      rx_vld <= 1'b0;
      if (!active)
      begin
        if (start_edge)
        begin
          active   <= 1'b1;
          baud_cnt <= CNT_W'(HALF_LOAD);
          bit_idx  <= '0;
        end
      end
      else if (tick)
      begin
        baud_cnt <= '0;
        if (bit_idx == 4'd0 && rx_s2)
        begin
          active <= 1'b0;  // glitch, not a real start bit
        end
        else if (bit_idx == 4'd10)
        begin
          active <= 1'b0;
          rx_vld <= 1'b1;
        end
        else
        begin
          bit_idx <= bit_idx + 4'd1;
        end
      end
      else
      begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (tick)
    begin
      if (bit_idx inside {[4'd1:4'd8]})
      begin
        data_sh <= {rx_s2, data_sh[7:1]};  // lsb arrives first
      end
      if (bit_idx == 4'd9)
      begin
        par_err_q <= ~(^{data_sh, rx_s2});  // odd parity expected
      end
      if (bit_idx == 4'd10)
      begin
        rx_frame <= frame_d;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/uart_cmd_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_consts.svh"

module uart_cmd_seq #(
  parameter int GAP_CYCLES    = `UART_GAP_CYCLES,
  parameter int REPLY_TIMEOUT = `UART_REPLY_TIMEOUT
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  uart_pkg::uart_cmd_t      cmd,
  input  logic                     cmd_vld,
  output logic                     cmd_rdy,
  output logic                     tx_start,
  output logic [7:0]               tx_byte,
  input  logic                     tx_busy,
  input  uart_pkg::uart_rx_frame_t rx_frame,
  input  logic                     rx_vld,
  input  logic                     rx_active,
  output uart_pkg::uart_read_t     read,
  output logic                     read_vld
);

  import uart_pkg::*;

  localparam int GAP_W = $clog2(GAP_CYCLES + 1);
  localparam int TMO_W = $clog2(REPLY_TIMEOUT + 1);

  typedef enum logic [2:0] {
    S_IDLE,
    S_HI,
    S_HI_WAIT,
    S_GAP,
    S_LO_WAIT,
    S_REPLY
  } state_t;

  state_t           state;
  uart_cmd_t        cmd_q;
  logic [GAP_W-1:0] gap_cnt;
  logic [TMO_W-1:0] tmo_cnt;
  logic             tx_done;
  logic             tmo_hit;
  logic             reply_err;

  assign cmd_rdy   = (state == S_IDLE);
  // tx_busy only rises the cycle after the start pulse
  assign tx_done   = !tx_busy && !tx_start;
  assign tx_byte   = (state == S_GAP || state == S_LO_WAIT) ? cmd_q.data
                                                            : {cmd_q.write, cmd_q.addr};
  assign tmo_hit   = !rx_active && (tmo_cnt == TMO_W'(REPLY_TIMEOUT - 1));
  assign reply_err = rx_frame.parity_err | rx_frame.stop_err;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= S_IDLE;
      tx_start <= 1'b0;
      gap_cnt  <= '0;
      tmo_cnt  <= '0;
      read_vld <= 1'b0;
    end
    else
    begin
      tx_start <= 1'b0;
      read_vld <= 1'b0;
      case (state)
        S_IDLE:
        begin
          if (cmd_vld)
          begin
            state <= S_HI;
          end
        end
        S_HI:
        begin
          if (!tx_busy)
          begin
            tx_start <= 1'b1;
            state    <= S_HI_WAIT;
          end
        end
        S_HI_WAIT:
        begin
          if (tx_done)
          begin
            gap_cnt <= '0;
            state   <= S_GAP;
          end
        end
        S_GAP:
        begin
          if (gap_cnt == GAP_W'(GAP_CYCLES - 1) && !tx_busy)
          begin
            tx_start <= 1'b1;
            state    <= S_LO_WAIT;
          end
          else
          begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end
        S_LO_WAIT:
        begin
          if (tx_done)
          begin
            tmo_cnt <= '0;
            state   <= cmd_q.write ? S_IDLE : S_REPLY;
          end
        end
        S_REPLY:
        begin
          if (rx_vld || tmo_hit)
          begin
            read_vld <= 1'b1;
            state    <= S_IDLE;
          end
          else if (!rx_active)
          begin
            tmo_cnt <= tmo_cnt + 1'b1;  // paused while a frame is arriving
          end
        end
        default:
        begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == S_IDLE && cmd_vld)
    begin
      cmd_q <= cmd;
    end
    if (state == S_REPLY)
    begin
      if (rx_vld)
      begin
        read <= '{data: rx_frame.data, err: reply_err};
      end
      else if (tmo_hit)
      begin
        read <= '{data: 8'h00, err: 1'b1};  // no reply seen
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/uart_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_consts.svh"

module uart_bridge #(
  parameter int BIT_CYCLES    = `UART_BIT_CYCLES,
  parameter int GAP_CYCLES    = `UART_GAP_CYCLES,
  parameter int REPLY_TIMEOUT = `UART_REPLY_TIMEOUT
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  uart_pkg::uart_cmd_t  cmd,
  input  logic                 cmd_vld,
  output logic                 cmd_rdy,
  input  logic                 rx,
  output logic                 tx,
  output uart_pkg::uart_read_t read,
  output logic                 read_vld
);

  logic                     tx_start;
  logic [7:0]               tx_byte;
  logic                     tx_busy;
  uart_pkg::uart_rx_frame_t rx_frame;
  logic                     rx_vld;
  logic                     rx_active;

  uart_cmd_seq #(
    .GAP_CYCLES   (GAP_CYCLES),
    .REPLY_TIMEOUT(REPLY_TIMEOUT)
  ) u_seq (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd      (cmd),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_busy  (tx_busy),
    .rx_frame (rx_frame),
    .rx_vld   (rx_vld),
    .rx_active(rx_active),
    .read     (read),
    .read_vld (read_vld)
  );

  uart_tx #(
    .BIT_CYCLES(BIT_CYCLES)
  ) u_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_start(tx_start),
    .tx_byte (tx_byte),
    .tx      (tx),
    .tx_busy (tx_busy)
  );

  uart_rx #(
    .BIT_CYCLES(BIT_CYCLES)
  ) u_rx (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .rx_frame (rx_frame),
    .rx_vld   (rx_vld),
    .rx_active(rx_active)
  );

endmodule

`default_nettype wire

// ==== testbench/uart_bridge_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_bridge_chk (
  input logic clk,
  input logic rst_n,
  input logic tx,
  input logic tx_busy,
  input logic tx_start,
  input logic cmd_rdy,
  input logic read_vld
);

  int unsigned fail_cnt;

  initial fail_cnt = 0;

  // line rests high between frames
  a_tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n) !tx_busy |-> tx)
  else
  begin
    $error("tx low while the transmitter is idle");
    fail_cnt++;
  end

  a_start_not_busy: assert property (@(posedge clk) disable iff (!rst_n) tx_start |-> !tx_busy)
  else
  begin
    $error("tx_start pulsed while the transmitter is busy");
    fail_cnt++;
  end

  a_read_pulse: assert property (@(posedge clk) disable iff (!rst_n) read_vld |=> !read_vld)
  else
  begin
    $error("read_vld high for two cycles in a row");
    fail_cnt++;
  end

  a_rdy_with_read: assert property (@(posedge clk) disable iff (!rst_n) read_vld |-> cmd_rdy)
  else
  begin
    $error("cmd_rdy low in the read_vld cycle");
    fail_cnt++;
  end

endmodule

bind uart_bridge uart_bridge_chk u_chk (
  .clk     (clk),
  .rst_n   (rst_n),
  .tx      (tx),
  .tx_busy (tx_busy),
  .tx_start(tx_start),
  .cmd_rdy (cmd_rdy),
  .read_vld(read_vld)
);

`default_nettype wire

// ==== testbench/uart_bridge_scoreboard.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_consts.svh"

module uart_bridge_scoreboard #(
  parameter int BIT_CYCLES = `UART_BIT_CYCLES
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 tx,
  input  logic                 cmd_rdy,
  input  uart_pkg::uart_read_t read,
  input  logic                 read_vld,
  input  logic                 exp_vld,
  input  uart_pkg::uart_cmd_t  exp_cmd,
  input  uart_pkg::uart_read_t exp_read,
  input  logic                 done,
  output int                   mismatch_cnt,
  output int                   other_cnt,
  output int                   frame_cnt
);

  import uart_pkg::*;

  logic [7:0] exp_bytes [$];
  uart_read_t exp_reads [$];
  int         push_cnt;
  logic       in_frame;
  int         phase;      // negedges since the start bit was seen
  int         bit_no;
  logic [9:0] bits;       // data lsb first, parity, stop
  logic       start_bad;
  logic [7:0] exp_byte;
  logic       exp_par;
  uart_read_t exp_r;
  logic       end_done;

  task automatic report_mismatch(input string sig, input logic [7:0] exp, input logic [7:0] got);
    $display("Mismatch at %0t: %s expected %h, got %h", $time, sig, exp, got);
    mismatch_cnt++;
  endtask

  task automatic check_frame();
    frame_cnt++;
    if (start_bad)
    begin
      $display("Error at %0t: start bit on tx did not hold low", $time);
      other_cnt++;
    end
    if (exp_bytes.size() == 0)
    begin
      $display("Error at %0t: extra frame on tx with no command pending", $time);
      other_cnt++;
    end
    else
    begin
      exp_byte = exp_bytes.pop_front();
      exp_par  = ($countones(exp_byte) % 2 == 0);  // total ones must be odd
      if (bits[7:0] !== exp_byte)
        report_mismatch("tx data", exp_byte, bits[7:0]);
      if (bits[8] !== exp_par)
        report_mismatch("tx parity", {7'd0, exp_par}, {7'd0, bits[8]});
    end
    if (bits[9] !== 1'b1)
      report_mismatch("tx stop", 8'h01, {7'd0, bits[9]});
  endtask

  always @(negedge clk)
  begin
    if (!rst_n)
    begin
      mismatch_cnt = 0;
      other_cnt    = 0;
      frame_cnt    = 0;
      push_cnt     = 0;
      in_frame     = 1'b0;
      end_done     = 1'b0;
    end
    else
    begin
      if (exp_vld)
      begin
        exp_bytes.push_back({exp_cmd.write, exp_cmd.addr});
        exp_bytes.push_back(exp_cmd.data);
        if (!exp_cmd.write)
          exp_reads.push_back(exp_read);
        push_cnt++;
      end
      else if (push_cnt == 0)
      begin
        // nothing may move before the first command
        if (tx !== 1'b1)
          report_mismatch("tx", 8'h01, {7'd0, tx});
        if (cmd_rdy !== 1'b1)
          report_mismatch("cmd_rdy", 8'h01, {7'd0, cmd_rdy});
        if (read_vld !== 1'b0)
          report_mismatch("read_vld", 8'h00, {7'd0, read_vld});
      end

      if (!in_frame)
      begin
        if (tx === 1'b0)
        begin
          in_frame  = 1'b1;
          phase     = 0;
          start_bad = 1'b0;
        end
      end
      else
      begin
        phase++;
        if (phase >= BIT_CYCLES / 2 && (phase - BIT_CYCLES / 2) % BIT_CYCLES == 0)
        begin
          bit_no = (phase - BIT_CYCLES / 2) / BIT_CYCLES;  // 0 is the start bit
          if (bit_no == 0)
            start_bad = (tx !== 1'b0);
          else
            bits[bit_no-1] = tx;
          if (bit_no == 10)
          begin
            check_frame();
            in_frame = 1'b0;
          end
        end
      end

      if (read_vld)
      begin
        if (exp_reads.size() == 0)
        begin
          $display("Error at %0t: read result with no read command pending", $time);
          other_cnt++;
        end
        else
        begin
          exp_r = exp_reads.pop_front();
          if (read.data !== exp_r.data)
            report_mismatch("read.data", exp_r.data, read.data);
          if (read.err !== exp_r.err)
            report_mismatch("read.err", {7'd0, exp_r.err}, {7'd0, read.err});
        end
      end

      if (done && !end_done)
      begin
        end_done = 1'b1;
        if (exp_bytes.size() != 0)
        begin
          $display("Error: %0d expected frames never appeared on tx", exp_bytes.size());
          other_cnt++;
        end
        if (exp_reads.size() != 0)
        begin
          $display("Error: %0d read results never arrived", exp_reads.size());
          other_cnt++;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== testbench/uart_bridge_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_consts.svh"

module uart_bridge_tb;

  import uart_pkg::*;

  localparam int BIT_CYCLES    = `UART_BIT_CYCLES;
  localparam int GAP_CYCLES    = `UART_GAP_CYCLES;
  localparam int REPLY_TIMEOUT = `UART_REPLY_TIMEOUT;
  localparam int N_ROWS        = 8;
  localparam int FRAME_CYCLES  = 11 * BIT_CYCLES;
  localparam int ROW_CYCLES    = 3 * FRAME_CYCLES + GAP_CYCLES + REPLY_TIMEOUT + 30;
  localparam int MAX_CYCLES    = N_ROWS * ROW_CYCLES + 100;  // reset and idle lead-in on top

  localparam logic [1:0] MODE_GOOD     = 2'd0;
  localparam logic [1:0] MODE_BAD_PAR  = 2'd1;
  localparam logic [1:0] MODE_BAD_STOP = 2'd2;
  localparam logic [1:0] MODE_NONE     = 2'd3;

  typedef struct packed {
    uart_cmd_t  cmd;
    logic [7:0] reply;
    logic [1:0] mode;
    uart_read_t exp;
  } row_t;

  logic       clk;
  logic       rst_n;
  uart_cmd_t  cmd;
  logic       cmd_vld;
  logic       cmd_rdy;
  logic       rx;
  logic       tx;
  uart_read_t read;
  logic       read_vld;
  logic       exp_vld;
  uart_cmd_t  exp_cmd;
  uart_read_t exp_read;
  logic       done;
  int         mismatch_cnt;
  int         other_cnt;
  int         frame_cnt;
  row_t       rows [N_ROWS];
  int         reply_q [$];
  int         hold;
  int         idx;
  int         tb_errs;
  int         total;
  int         cycles;

  uart_bridge #(
    .BIT_CYCLES   (BIT_CYCLES),
    .GAP_CYCLES   (GAP_CYCLES),
    .REPLY_TIMEOUT(REPLY_TIMEOUT)
  ) u_dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd     (cmd),
    .cmd_vld (cmd_vld),
    .cmd_rdy (cmd_rdy),
    .rx      (rx),
    .tx      (tx),
    .read    (read),
    .read_vld(read_vld)
  );

  uart_bridge_scoreboard #(
    .BIT_CYCLES(BIT_CYCLES)
  ) u_sb (
    .clk         (clk),
    .rst_n       (rst_n),
    .tx          (tx),
    .cmd_rdy     (cmd_rdy),
    .read        (read),
    .read_vld    (read_vld),
    .exp_vld     (exp_vld),
    .exp_cmd     (exp_cmd),
    .exp_read    (exp_read),
    .done        (done),
    .mismatch_cnt(mismatch_cnt),
    .other_cnt   (other_cnt),
    .frame_cnt   (frame_cnt)
  );

  task automatic set_row(input int i, input logic wr, input logic [6:0] addr,
                         input logic [7:0] data, input logic [7:0] reply, input logic [1:0] mode,
                         input logic [7:0] exp_data, input logic exp_err);
    rows[i].cmd   = {wr, addr, data};
    rows[i].reply = reply;
    rows[i].mode  = mode;
    rows[i].exp   = {exp_data, exp_err};
  endtask

  // waits past the middle of the stop bit of the next frame on tx
  task automatic wait_frame_on_tx();
    do @(negedge clk); while (tx !== 1'b0);
    repeat (10 * BIT_CYCLES + BIT_CYCLES / 2) @(negedge clk);
  endtask

  task automatic send_reply(input logic [7:0] b, input logic [1:0] mode);
    logic [9:0] bits;
    int         i;
    bits[7:0] = b;
    bits[8]   = ($countones(b) % 2 == 0) ^ (mode == MODE_BAD_PAR);
    bits[9]   = (mode != MODE_BAD_STOP);
    @(posedge clk);
    #10;
    rx = 1'b0;  // start bit
    for (i = 0; i < 10; i++)
    begin
      repeat (BIT_CYCLES) @(posedge clk);
      #10;
      rx = bits[i];
    end
    repeat (BIT_CYCLES) @(posedge clk);
    #10;
    rx = 1'b1;
  endtask

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // serial reply model, one pass per accepted command
  initial
  begin
    rx = 1'b1;
    forever
    begin
      while (reply_q.size() == 0) @(negedge clk);
      idx = reply_q.pop_front();
      repeat (2) wait_frame_on_tx();
      if (!rows[idx].cmd.write && rows[idx].mode != MODE_NONE)
      begin
        repeat (3 * BIT_CYCLES + BIT_CYCLES / 2) @(negedge clk);
        send_reply(rows[idx].reply, rows[idx].mode);
      end
    end
  end

  initial
  begin
    cycles = 0;
    while (cycles < MAX_CYCLES)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("Error: run did not finish within %0d cycles", MAX_CYCLES);
    $display("Test FAILED");
    $finish;
  end

  initial
  begin
    void'($urandom(61));
    rst_n    = 1'b0;
    cmd      = '0;
    cmd_vld  = 1'b0;
    exp_vld  = 1'b0;
    exp_cmd  = '0;
    exp_read = '0;
    done     = 1'b0;
    tb_errs  = 0;
    set_row(0, 1'b1, 7'h12, 8'ha5, 8'h00, MODE_NONE,     8'h00, 1'b0);
    set_row(1, 1'b0, 7'h05, 8'h00, 8'h3c, MODE_GOOD,     8'h3c, 1'b0);
    set_row(2, 1'b0, 7'h7f, 8'h11, 8'h81, MODE_BAD_PAR,  8'h81, 1'b1);
    set_row(3, 1'b1, 7'h40, 8'h00, 8'h00, MODE_NONE,     8'h00, 1'b0);
    set_row(4, 1'b0, 7'h21, 8'h00, 8'hff, MODE_BAD_STOP, 8'hff, 1'b1);
    set_row(5, 1'b0, 7'h33, 8'h00, 8'h5a, MODE_NONE,     8'h00, 1'b1);  // timeout
    set_row(6, 1'b0, 7'h0a, 8'h00, 8'h00, MODE_GOOD,     8'h00, 1'b0);
    set_row(7, 1'b1, 7'h7f, 8'hff, 8'h00, MODE_NONE,     8'h00, 1'b0);

    repeat (8) @(posedge clk);
    #10;
    rst_n = 1'b1;
    repeat (20) @(posedge clk);  // quiet stretch before the first command
    #10;

    for (int r = 0; r < N_ROWS; r++)
    begin
      hold = $urandom % 6;
      repeat (hold)
      begin
        @(posedge clk);
        #10;
      end
      cmd     = rows[r].cmd;
      cmd_vld = 1'b1;  // stays up while the previous command is still busy
      do @(negedge clk); while (!cmd_rdy);
      @(posedge clk);
      #10;
      cmd_vld  = 1'b0;
      exp_vld  = 1'b1;
      exp_cmd  = rows[r].cmd;
      exp_read = rows[r].exp;
      reply_q.push_back(r);
      @(posedge clk);
      #10;
      exp_vld = 1'b0;
    end

    do @(negedge clk); while (!cmd_rdy);
    repeat (2 * BIT_CYCLES) @(negedge clk);
    done = 1'b1;
    @(negedge clk);
    @(negedge clk);
    if (frame_cnt != 2 * N_ROWS)
    begin
      $display("Error: %0d frames seen on tx, expected %0d", frame_cnt, 2 * N_ROWS);
      tb_errs++;
    end
    total = mismatch_cnt + other_cnt + tb_errs + int'(u_dut.u_chk.fail_cnt);
    $display("errors: %0d mismatch, %0d other, %0d assertion",
             mismatch_cnt, other_cnt + tb_errs, u_dut.u_chk.fail_cnt);
    if (total == 0)
    begin
      $display("Test OK");
    end
    else
    begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
logic/uart_pkg.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_cmd_seq.sv
logic/uart_bridge.sv
testbench/uart_bridge_chk.sv
testbench/uart_bridge_scoreboard.sv
testbench/uart_bridge_tb.sv

// ==== Bender.yml ====
package:
  name: uart_bridge

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/uart_pkg.sv
      - logic/uart_tx.sv
      - logic/uart_rx.sv
      - logic/uart_cmd_seq.sv
      - logic/uart_bridge.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/uart_bridge_chk.sv
      - testbench/uart_bridge_scoreboard.sv
      - testbench/uart_bridge_tb.sv
